// File: coef_counter.sv
`timescale 1ns/1ps
`include "wht_params.svh"

module coef_counter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear_i,
    input  logic               en_i,
    output wht_pkg::coef_idx_t count_o,
    output logic               last_o
);

    // Position counter, wraps after the final index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_o <= '0;
        end else if (clear_i) begin // Clear wins over enable
            count_o <= '0;
        end else if (en_i) begin
            count_o <= count_o + 1'b1;
        end
    end

    assign last_o = (count_o == wht_pkg::coef_idx_t'(`WHT_N - 1));

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Away from the last position and without a clear, the count only
    // moves up or holds
    property p_no_early_wrap;
        @(posedge clk) disable iff (!rst_n)
        (!clear_i && !last_o) |=> (count_o >= $past(count_o));
    endproperty

    a_no_early_wrap : assert property (p_no_early_wrap)
        else $error("coef_counter wrapped before the last index");

endmodule

// File: coef_serializer.sv
`timescale 1ns/1ps
`include "wht_params.svh"

module coef_serializer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         sel_valid_i,
    input  logic                         sel_last_i,
    input  wht_pkg::coef_idx_t           sel_idx_i,
    input  logic [`WHT_N*`WHT_OUT_W-1:0] block_i,
    output wht_pkg::wht_coef_t           coef_o,
    output wht_pkg::coef_idx_t           coef_idx_o,
    output logic                         coef_valid_o,
    output logic                         last_o
);

    wht_pkg::wht_coef_t lane_sel;

    // Pick the addressed lane off the flat bus
    assign lane_sel = block_i[sel_idx_i*`WHT_OUT_W +: `WHT_OUT_W];

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coef_valid_o <= 1'b0;
            last_o       <= 1'b0;
        end else begin
            coef_valid_o <= sel_valid_i;
            last_o       <= sel_valid_i && sel_last_i; // Only with index 15
        end
    end

    // Data and index follow the select, held between runs
    always_ff @(posedge clk) begin
        if (sel_valid_i) begin
            coef_o     <= lane_sel;
            coef_idx_o <= sel_idx_i;
        end
    end

endmodule

// File: dc_collector.sv
`timescale 1ns/1ps
`include "wht_params.svh"

module dc_collector (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_en_i,
    input  wht_pkg::coef_idx_t              wr_idx_i,
    input  wht_pkg::dc_coef_t               dc_i,
    output logic [`WHT_N*`WHT_IN_W-1:0]     block_o
);

    // DC terms of the current macroblock in raster order
    wht_pkg::dc_coef_t dc_mem [`WHT_N];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `WHT_N; k++) begin
                dc_mem[k] <= '0;
            end
        end else if (wr_en_i) begin
            dc_mem[wr_idx_i] <= dc_i;
        end
    end

    // ----------------------------------------
    // Flatten onto the transform bus
    // ----------------------------------------
    genvar g;
    generate
        for (g = 0; g < `WHT_N; g++) begin : g_lane
            assign block_o[g*`WHT_IN_W +: `WHT_IN_W] = dc_mem[g]; // Lane g at bit g*12
        end
    endgenerate

endmodule

// File: fwd_wht.sv
`timescale 1ns/1ps
`include "wht_params.svh"

module fwd_wht (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_i,
    input  logic [`WHT_N*`WHT_IN_W-1:0]  block_i,
    output logic [`WHT_N*`WHT_OUT_W-1:0] block_o,
    output logic                         done_o
);

    wht_pkg::dc_coef_t               x_in  [`WHT_N];
    logic signed [`WHT_MID_W-1:0]    t_row [`WHT_N]; // Row pass results
    wht_pkg::wht_coef_t              y_q   [`WHT_N];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_o <= 1'b0;
        end else begin
            done_o <= start_i;
        end
    end

    genvar i;
    generate
        // Unpack input lanes and pack the registered result
        for (i = 0; i < `WHT_N; i++) begin : g_lane
            assign x_in[i]                             = block_i[i*`WHT_IN_W +: `WHT_IN_W];
            assign block_o[i*`WHT_OUT_W +: `WHT_OUT_W] = y_q[i];
        end

        // ----------------------------------------
        // Horizontal butterflies, one per row
        // ----------------------------------------
        for (i = 0; i < `WHT_DIM; i++) begin : g_row
            logic signed [`WHT_IN_W:0] a0;
            logic signed [`WHT_IN_W:0] a1;
            logic signed [`WHT_IN_W:0] a2;
            logic signed [`WHT_IN_W:0] a3;

            assign a0 = x_in[`WHT_DIM*i + 0] + x_in[`WHT_DIM*i + 2];
            assign a1 = x_in[`WHT_DIM*i + 1] + x_in[`WHT_DIM*i + 3];
            assign a2 = x_in[`WHT_DIM*i + 1] - x_in[`WHT_DIM*i + 3];
            assign a3 = x_in[`WHT_DIM*i + 0] - x_in[`WHT_DIM*i + 2];

            assign t_row[`WHT_DIM*i + 0] = a0 + a1;
            assign t_row[`WHT_DIM*i + 1] = a3 + a2;
            assign t_row[`WHT_DIM*i + 2] = a3 - a2;
            assign t_row[`WHT_DIM*i + 3] = a0 - a1;
        end

        // ----------------------------------------
        // Vertical butterflies and the halving
        // ----------------------------------------
        for (i = 0; i < `WHT_DIM; i++) begin : g_col
            logic signed [`WHT_OUT_W-1:0] b0;
            logic signed [`WHT_OUT_W-1:0] b1;
            logic signed [`WHT_OUT_W-1:0] b2;
            logic signed [`WHT_OUT_W-1:0] b3;
            logic signed [`WHT_OUT_W:0]   s0; // One guard bit so -32768 survives
            logic signed [`WHT_OUT_W:0]   s1;
            logic signed [`WHT_OUT_W:0]   s2;
            logic signed [`WHT_OUT_W:0]   s3;

            assign b0 = t_row[i + 0] + t_row[i + 8];
            assign b1 = t_row[i + 4] + t_row[i + 12];
            assign b2 = t_row[i + 4] - t_row[i + 12];
            assign b3 = t_row[i + 0] - t_row[i + 8];

            assign s0 = b0 + b1;
            assign s1 = b3 + b2;
            assign s2 = b3 - b2;
            assign s3 = b0 - b1;

            // Bits [15:1] are the arithmetic shift by one, cut to 15 bits
            always_ff @(posedge clk) begin
                if (start_i) begin // Held stable while the serializer reads it
                    y_q[i + 0]  <= s0[`WHT_OUT_W:1];
                    y_q[i + 4]  <= s1[`WHT_OUT_W:1];
                    y_q[i + 8]  <= s2[`WHT_OUT_W:1];
                    y_q[i + 12] <= s3[`WHT_OUT_W:1];
                end
            end
        end
    endgenerate

endmodule

// File: luma_dc_top.sv
`timescale 1ns/1ps
`include "wht_params.svh"

module luma_dc_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dc_valid_i,
    input  wht_pkg::dc_coef_t  dc_i,
    output logic               busy_o,
    output logic               coef_valid_o,
    output wht_pkg::wht_coef_t coef_o,
    output wht_pkg::coef_idx_t coef_idx_o,
    output logic               last_o
);

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------
    wht_pkg::coef_idx_t           count;
    logic                         cnt_last;
    logic                         cnt_clear;
    logic                         cnt_en;
    logic                         wht_start;
    logic                         wht_done;
    logic                         out_sel_valid;
    logic                         out_last;
    logic [`WHT_N*`WHT_IN_W-1:0]  dc_block;  // Collected DC matrix
    logic [`WHT_N*`WHT_OUT_W-1:0] wht_block; // Transformed matrix

    coef_counter u_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear_i (cnt_clear),
        .en_i    (cnt_en),
        .count_o (count),
        .last_o  (cnt_last)
    );

    wht_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .dc_valid_i      (dc_valid_i),
        .cnt_last_i      (cnt_last),
        .wht_done_i      (wht_done),
        .cnt_clear_o     (cnt_clear),
        .cnt_en_o        (cnt_en),
        .wht_start_o     (wht_start),
        .out_sel_valid_o (out_sel_valid),
        .out_last_o      (out_last),
        .busy_o          (busy_o)
    );

    // Written only on collect strobes, cnt_en doubles as the write enable
    dc_collector u_collector (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en_i  (cnt_en && !busy_o),
        .wr_idx_i (count),
        .dc_i     (dc_i),
        .block_o  (dc_block)
    );

    fwd_wht u_wht (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (wht_start),
        .block_i (dc_block),
        .block_o (wht_block),
        .done_o  (wht_done)
    );

    coef_serializer u_serializer (
        .clk          (clk),
        .rst_n        (rst_n),
        .sel_valid_i  (out_sel_valid),
        .sel_last_i   (out_last),
        .sel_idx_i    (count),
        .block_i      (wht_block),
        .coef_o       (coef_o),
        .coef_idx_o   (coef_idx_o),
        .coef_valid_o (coef_valid_o),
        .last_o       (last_o)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the luma DC testbench with Verilator and run it.
# The exit status is the simulator's, so any $fatal gives a failing status.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module tb_luma_dc \
    && ./obj_dir/Vtb_luma_dc \
    || { echo "Build or simulation ended with an error"; exit 1; }

// File: tb_luma_dc.sv
`timescale 1ns/1ps
`include "wht_params.svh"

module tb_luma_dc;

    localparam int TIMEOUT   = 100; // Cycles allowed for any single wait
    localparam int N_RANDOM  = 30;

    logic               clk;
    logic               rst_n;
    logic               dc_valid_i;
    wht_pkg::dc_coef_t  dc_i;
    logic               busy_o;
    logic               coef_valid_o;
    wht_pkg::wht_coef_t coef_o;
    wht_pkg::coef_idx_t coef_idx_o;
    logic               last_o;

    logic [31:0]        lfsr_q;
    wht_pkg::dc_coef_t  blk   [`WHT_N]; // Block being sent
    wht_pkg::wht_coef_t exp_q [`WHT_N]; // Model result for it

    luma_dc_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .dc_valid_i   (dc_valid_i),
        .dc_i         (dc_i),
        .busy_o       (busy_o),
        .coef_valid_o (coef_valid_o),
        .coef_o       (coef_o),
        .coef_idx_o   (coef_idx_o),
        .last_o       (last_o)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Random source
    // ----------------------------------------

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_next_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_next_bit()}; // One step per bit
        end
        return v;
    endfunction

    // ----------------------------------------
    // Error handling and compares
    // ----------------------------------------
    task automatic abort_run(input string what);
        $display("** FAIL **");
        $fatal(1, "Run stopped: %s", what);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        abort_run("timeout");
    endtask

    task automatic check_coef(input string name, input wht_pkg::wht_coef_t exp,
                              input wht_pkg::wht_coef_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, exp, act);
            abort_run("coefficient compare");
        end
    endtask

    task automatic check_idx(input string name, input wht_pkg::coef_idx_t exp,
                             input wht_pkg::coef_idx_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, exp, act);
            abort_run("index compare");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, exp, act);
            abort_run("flag compare");
        end
    endtask

    // Nothing may come out while a block is being collected
    task automatic check_idle_outputs();
        check_bit("busy_o", 1'b0, busy_o);
        check_bit("coef_valid_o", 1'b0, coef_valid_o);
        check_bit("last_o", 1'b0, last_o);
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic wht_pkg::wht_coef_t floor_half(input int v);
        return wht_pkg::wht_coef_t'(v >>> 1); // Floor division then cut to 15 bits
    endfunction

    task automatic compute_expected();
        int t [`WHT_N];
        int a0;
        int a1;
        int a2;
        int a3;
        for (int r = 0; r < 4; r++) begin // Row pass
            a0 = int'(blk[4*r + 0]) + int'(blk[4*r + 2]);
            a1 = int'(blk[4*r + 1]) + int'(blk[4*r + 3]);
            a2 = int'(blk[4*r + 1]) - int'(blk[4*r + 3]);
            a3 = int'(blk[4*r + 0]) - int'(blk[4*r + 2]);
            t[4*r + 0] = a0 + a1;
            t[4*r + 1] = a3 + a2;
            t[4*r + 2] = a3 - a2;
            t[4*r + 3] = a0 - a1;
        end
        for (int c = 0; c < 4; c++) begin // Column pass
            a0 = t[c + 0] + t[c + 8];
            a1 = t[c + 4] + t[c + 12];
            a2 = t[c + 4] - t[c + 12];
            a3 = t[c + 0] - t[c + 8];
            exp_q[c + 0]  = floor_half(a0 + a1);
            exp_q[c + 4]  = floor_half(a3 + a2);
            exp_q[c + 8]  = floor_half(a3 - a2);
            exp_q[c + 12] = floor_half(a0 - a1);
        end
    endtask

    // ----------------------------------------
    // Block contents
    // ----------------------------------------
    task automatic fill_const(input wht_pkg::dc_coef_t v);
        for (int k = 0; k < `WHT_N; k++) begin
            blk[k] = v;
        end
    endtask

    task automatic fill_alternating();
        for (int k = 0; k < `WHT_N; k++) begin
            blk[k] = (k % 2 == 0) ? 12'sd2047 : -12'sd2048;
        end
    endtask

    task automatic fill_random();
        for (int k = 0; k < `WHT_N; k++) begin
            blk[k] = wht_pkg::dc_coef_t'(rand_bits(`WHT_IN_W));
        end
    endtask

    // ----------------------------------------
    // Source and sink
    // ----------------------------------------
    task automatic wait_not_busy();
        int n;
        n = 0;
        @(negedge clk);
        while (busy_o) begin
            if (n >= TIMEOUT) begin
                report_timeout("busy_o to fall");
            end
            n++;
            @(negedge clk);
        end
    endtask

    // Ends on edge E which samples the 16th strobe
    task automatic send_block();
        int gap;
        wait_not_busy();
        for (int k = 0; k < `WHT_N; k++) begin
            gap = int'(rand_bits(2)); // 0 to 3 idle cycles
            repeat (gap) begin
                @(posedge clk);
                dc_valid_i <= 1'b0;
                @(negedge clk);
                check_idle_outputs();
            end
            @(posedge clk);
            dc_valid_i <= 1'b1;
            dc_i       <= blk[k];
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        dc_valid_i <= 1'b0;
    endtask

    task automatic collect_outputs();
        int edges;
        edges = 0;
        // First result is due right after E+3
        do begin
            @(negedge clk);
            edges++;
            if (edges > TIMEOUT) begin
                report_timeout("the first coef_valid_o");
            end
            check_bit("busy_o", 1'b1, busy_o);
            check_bit("coef_valid_o", logic'(edges >= 4), coef_valid_o);
        end while (!coef_valid_o);

        for (int k = 0; k < `WHT_N; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            check_bit("coef_valid_o", 1'b1, coef_valid_o);
            check_idx("coef_idx_o", wht_pkg::coef_idx_t'(k), coef_idx_o);
            check_coef("coef_o", exp_q[k], coef_o);
            check_bit("last_o", logic'(k == `WHT_N - 1), last_o);
            check_bit("busy_o", logic'(k != `WHT_N - 1), busy_o); // Drops with index 15
        end

        // Exactly sixteen results per block
        @(negedge clk);
        check_bit("coef_valid_o", 1'b0, coef_valid_o);
        check_bit("last_o", 1'b0, last_o);
    endtask

    task automatic run_block();
        compute_expected();
        send_block();
        collect_outputs();
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        dc_valid_i = 1'b0;
        dc_i       = '0;
        lfsr_q     = 32'h35ec;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Corner blocks for sign, widening and the floor shift
        fill_const(-12'sd2048);
        run_block();
        fill_const(12'sd2047);
        run_block();
        fill_alternating();
        run_block();
        fill_const('0);
        run_block();

        for (int b = 0; b < N_RANDOM; b++) begin
            fill_random();
            run_block();
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
wht_pkg.sv
coef_counter.sv
wht_ctrl.sv
dc_collector.sv
fwd_wht.sv
coef_serializer.sv
luma_dc_top.sv
tb_luma_dc.sv

// File: wht_ctrl.sv
`timescale 1ns/1ps

module wht_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic dc_valid_i,
    input  logic cnt_last_i,
    input  logic wht_done_i,
    output logic cnt_clear_o,
    output logic cnt_en_o,
    output logic wht_start_o,
    output logic out_sel_valid_o,
    output logic out_last_o,
    output logic busy_o
);

    wht_pkg::ctrl_state_t state_q;
    wht_pkg::ctrl_state_t state_d;
    logic                 in_collect;
    logic                 in_transform;
    logic                 in_output;
    logic                 last_strobe;

    assign in_collect   = (state_q == wht_pkg::S_COLLECT);
    assign in_transform = (state_q == wht_pkg::S_TRANSFORM);
    assign in_output    = (state_q == wht_pkg::S_OUTPUT);

    // 16th coefficient of the macroblock
    assign last_strobe  = in_collect && dc_valid_i && cnt_last_i;

    // ----------------------------------------
    // State register and next state
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            wht_pkg::S_COLLECT: begin
                if (last_strobe) begin
                    state_d = wht_pkg::S_TRANSFORM;
                end
            end
            wht_pkg::S_TRANSFORM: begin
                if (wht_done_i) begin
                    state_d = wht_pkg::S_OUTPUT;
                end
            end
            wht_pkg::S_OUTPUT: begin
                if (cnt_last_i) begin // Index 15 goes out now
                    state_d = wht_pkg::S_COLLECT;
                end
            end
            default: state_d = wht_pkg::S_COLLECT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= wht_pkg::S_COLLECT;
            wht_start_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            wht_start_o <= last_strobe; // One cycle pulse
        end
    end

    // ----------------------------------------
    // Counter and serializer control
    // ----------------------------------------

    // Rewind before the output run and again after it
    assign cnt_clear_o     = (in_transform && wht_done_i) || (in_output && cnt_last_i);
    assign cnt_en_o        = (in_collect && dc_valid_i) || in_output;

    assign out_sel_valid_o = in_output;
    assign out_last_o      = in_output && cnt_last_i;

    assign busy_o          = !in_collect;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // No back-pressure exists, so the source has to honour busy_o
    a_no_strobe_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        busy_o |-> !dc_valid_i
    ) else $error("dc_valid_i strobed while busy_o is high");

    // The transform answers exactly one cycle after its start pulse
    a_done_after_start : assert property (
        @(posedge clk) disable iff (!rst_n)
        wht_done_i |-> (in_transform && $past(wht_start_o))
    ) else $error("wht_done_i outside S_TRANSFORM or not after start");

endmodule

// File: wht_params.svh
`ifndef WHT_PARAMS_SVH
`define WHT_PARAMS_SVH

// Side of the DC matrix, the butterfly wiring assumes 4
`define WHT_DIM     4

// Coefficients per macroblock
`define WHT_N       16

// Widths through the transform
`define WHT_IN_W    12 // DC term from the 4x4 block transforms
`define WHT_MID_W   14 // After the row pass
`define WHT_OUT_W   15 // Final result after the halving

`endif

// File: wht_pkg.sv
`include "wht_params.svh"

package wht_pkg;

    // ----------------------------------------
    // Coefficient words
    // ----------------------------------------

    // Input DC term, one per 4x4 luma block
    typedef logic signed [`WHT_IN_W-1:0]  dc_coef_t;

    // Transformed coefficient
    typedef logic signed [`WHT_OUT_W-1:0] wht_coef_t;

    // Raster position inside the 4x4 DC matrix
    typedef logic [$clog2(`WHT_N)-1:0]    coef_idx_t;

    // ----------------------------------------
    // Controller states
    // ----------------------------------------
    typedef enum logic [1:0] {
        S_COLLECT   = 2'd0, // Taking in DC terms
        S_TRANSFORM = 2'd1, // Waiting on the butterfly register
        S_OUTPUT    = 2'd2  // Streaming results
    } ctrl_state_t;

endpackage
